// File: audio_consts.svh
// Audio path constants: sample and sum widths, volume code width, speaker base, compressor curves
`ifndef AUDIO_CONSTS_SVH
`define AUDIO_CONSTS_SVH

//////////////////////////////
// Widths
//////////////////////////////

`define AUDIO_W 16
`define SUM_W 17
`define VOL_W 5

// Speaker tone sits at bit 11 before boost
`define SPK_BASE_SHIFT 11

//////////////////////////////
// Compressor curves
//////////////////////////////

// Curve 1, gain 2 below knee, slope 1/4 above
`define COMP_X1 14043
`define COMP_A1 2
`define COMP_F1 4
`define COMP_B1 28086

// Curve 2, gain 4 below knee, slope 1/8 above
`define COMP_X2 7399
`define COMP_A2 4
`define COMP_F2 8
`define COMP_B2 29596

`endif

// File: audio_pkg.sv
// Audio types: stereo sample, mixer settings, wide mix sum, and the volume shift function
`default_nettype none
`include "audio_consts.svh"

package audio_pkg;

	typedef struct packed {
		logic signed [`AUDIO_W-1:0] l;
		logic signed [`AUDIO_W-1:0] r;
	} stereo_t;

	// Sum before clamping, one guard bit
	typedef struct packed {
		logic signed [`SUM_W-1:0] l;
		logic signed [`SUM_W-1:0] r;
	} mix_sum_t;

	typedef struct packed {
		logic [`VOL_W-1:0] vol_midi_l;
		logic [`VOL_W-1:0] vol_midi_r;
		logic [`VOL_W-1:0] vol_line_l;
		logic [`VOL_W-1:0] vol_line_r;
		logic [`VOL_W-1:0] master_l;
		logic [`VOL_W-1:0] master_r;
		logic              midi_src_line;
		logic              line_en;
		logic              cd_en;
		logic [1:0]        spk_vol;
		logic [1:0]        spk_boost;
		// 0 off, 1 curve 1, 2 or 3 curve 2
		logic [1:0]        boost;
	} mix_cfg_t;

	// Zero code mutes, otherwise 6 dB per step of the upper four bits
	function automatic logic signed [`AUDIO_W-1:0] vol_scale(
		input logic signed [`AUDIO_W-1:0] sample,
		input logic [`VOL_W-1:0]          code
	);
		if (code == '0) begin
			return '0;
		end
		return sample >>> (`AUDIO_W - 1 - code[`VOL_W-1:1]);
	endfunction

endpackage

`default_nettype wire

// File: sample_stabilizer.sv
// Two-register synchronizer that forwards a payload only once it holds steady
`timescale 1ns/100ps
`default_nettype none

module sample_stabilizer #(
	parameter type payload_t = logic
) (
	input  logic     clk_sys,
	input  logic     reset,
	input  payload_t din,
	output payload_t dout
);

	payload_t stage_a;
	payload_t stage_b;

	// A value caught mid-change shows up as a mismatch and is not passed
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			stage_a <= '0;
			stage_b <= '0;
			dout    <= '0;
		end else begin
			stage_a <= din;
			stage_b <= stage_a;
			if (stage_a == stage_b) begin
				dout <= stage_b;
			end
		end
	end

endmodule

`default_nettype wire

// File: source_mixer.sv
// Source mixer: MIDI volume, speaker level, five-way sum and 16-bit clamp
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

module source_mixer (
	input  logic                 clk_sys,
	input  logic                 reset,
	input  audio_pkg::stereo_t   sb,
	input  audio_pkg::stereo_t   opl,
	input  audio_pkg::stereo_t   midi,
	input  audio_pkg::stereo_t   cdda,
	input  logic                 speaker,
	input  audio_pkg::mix_cfg_t  cfg,
	output audio_pkg::stereo_t   mix_out
);

	localparam int SW = `SUM_W;

	logic [`VOL_W-1:0]    midi_vol_l;
	logic [`VOL_W-1:0]    midi_vol_r;
	logic [SW-1:0]        spk_full;
	logic signed [SW-1:0] spk_level;

	audio_pkg::stereo_t   midi_q;
	audio_pkg::stereo_t   opl_q;
	audio_pkg::stereo_t   sb_q;
	audio_pkg::stereo_t   cdda_q;
	logic signed [SW-1:0] spk_q;
	audio_pkg::mix_sum_t  sum_q;

	// Saturate to the nearest 16-bit limit when the guard bit disagrees
	function automatic logic signed [`AUDIO_W-1:0] clamp16(input logic signed [SW-1:0] s);
		if (s[SW-1] != s[SW-2]) begin
			return {s[SW-1], {(`AUDIO_W-1){~s[SW-1]}}};
		end
		return s[`AUDIO_W-1:0];
	endfunction

	//////////////////////////////
	// Volume and speaker level
	//////////////////////////////

	// Line-in volume takes over when MIDI is routed through line
	always_comb begin
		if (!cfg.midi_src_line) begin
			midi_vol_l = cfg.vol_midi_l;
			midi_vol_r = cfg.vol_midi_r;
		end else if (cfg.line_en) begin
			midi_vol_l = cfg.vol_line_l;
			midi_vol_r = cfg.vol_line_r;
		end else begin
			midi_vol_l = '0;
			midi_vol_r = '0;
		end
	end

	// Speaker is a single bit, always positive after placement
	always_comb begin
		spk_full = '0;
		spk_full[`SPK_BASE_SHIFT + cfg.spk_boost] = speaker;
		spk_level = signed'(spk_full >> (2'd3 - cfg.spk_vol));
	end

	//////////////////////////////
	// Three registered steps
	//////////////////////////////

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			midi_q  <= '0;
			opl_q   <= '0;
			sb_q    <= '0;
			cdda_q  <= '0;
			spk_q   <= '0;
			sum_q   <= '0;
			mix_out <= '0;
		end else begin
			// Step 1
			midi_q.l <= audio_pkg::vol_scale(midi.l, midi_vol_l);
			midi_q.r <= audio_pkg::vol_scale(midi.r, midi_vol_r);
			opl_q    <= opl;
			sb_q     <= sb;
			cdda_q   <= cfg.cd_en ? cdda : '0;
			spk_q    <= spk_level;

			// Step 2, everything sign-extended to the sum width
			sum_q.l <= SW'(opl_q.l) + SW'(sb_q.l) + spk_q + SW'(midi_q.l) + SW'(cdda_q.l);
			sum_q.r <= SW'(opl_q.r) + SW'(sb_q.r) + spk_q + SW'(midi_q.r) + SW'(cdda_q.r);

			// Step 3
			mix_out.l <= clamp16(sum_q.l);
			mix_out.r <= clamp16(sum_q.r);
		end
	end

endmodule

`default_nettype wire

// File: dynamics_compressor.sv
// Single-channel soft compressor, four pipeline steps, two selectable curves
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

module dynamics_compressor (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       curve_sel,
	input  logic signed [`AUDIO_W-1:0] din,
	output logic signed [`AUDIO_W-1:0] dout
);

	logic [`AUDIO_W-1:0] mag_q;
	logic [`AUDIO_W-1:0] c1_q;
	logic [`AUDIO_W-1:0] c2_q;
	logic [`AUDIO_W-1:0] sel_q;
	logic                sign_q;
	logic                sign2_q;
	logic                sign3_q;

	// Linear gain below the knee, shallow slope plus offset above it
	function automatic logic [`AUDIO_W-1:0] curve(
		input logic [`AUDIO_W-1:0] mag,
		input int unsigned         x,
		input int unsigned         a,
		input int unsigned         f,
		input int unsigned         b
	);
		if (mag < x) begin
			return `AUDIO_W'(mag * a);
		end
		return `AUDIO_W'((mag - x) / f + b);
	endfunction

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			mag_q   <= '0;
			sign_q  <= 1'b0;
			c1_q    <= '0;
			c2_q    <= '0;
			sign2_q <= 1'b0;
			sel_q   <= '0;
			sign3_q <= 1'b0;
			dout    <= '0;
		end else begin
			// Magnitude wraps, so -32768 stays 0x8000
			mag_q  <= din[`AUDIO_W-1] ? -din : din;
			sign_q <= din[`AUDIO_W-1];

			c1_q    <= curve(mag_q, `COMP_X1, `COMP_A1, `COMP_F1, `COMP_B1);
			c2_q    <= curve(mag_q, `COMP_X2, `COMP_A2, `COMP_F2, `COMP_B2);
			sign2_q <= sign_q;

			sel_q   <= curve_sel ? c2_q : c1_q;
			sign3_q <= sign2_q;

			dout <= sign3_q ? -sel_q : sel_q;
		end
	end

endmodule

`default_nettype wire

// File: master_output.sv
// Master output: boost compressors per channel, bypass delay, master volume
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

module master_output (
	input  logic                clk_sys,
	input  logic                reset,
	input  audio_pkg::stereo_t  mix_in,
	input  audio_pkg::mix_cfg_t cfg,
	output audio_pkg::stereo_t  audio_out
);

	// Matches the compressor pipeline depth
	localparam int COMP_LAT = 4;

	logic signed [`AUDIO_W-1:0] comp_l;
	logic signed [`AUDIO_W-1:0] comp_r;
	audio_pkg::stereo_t         raw_dly [COMP_LAT];
	audio_pkg::stereo_t         pick;

	dynamics_compressor comp_left (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.curve_sel (cfg.boost[1]),
		.din       (mix_in.l),
		.dout      (comp_l)
	);

	dynamics_compressor comp_right (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.curve_sel (cfg.boost[1]),
		.din       (mix_in.r),
		.dout      (comp_r)
	);

	// Uncompressed copy kept in step with the compressor
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			for (int i = 0; i < COMP_LAT; i++) begin
				raw_dly[i] <= '0;
			end
		end else begin
			raw_dly[0] <= mix_in;
			for (int i = 1; i < COMP_LAT; i++) begin
				raw_dly[i] <= raw_dly[i-1];
			end
		end
	end

	always_comb begin
		if (cfg.boost != 2'd0) begin
			pick.l = comp_l;
			pick.r = comp_r;
		end else begin
			pick = raw_dly[COMP_LAT-1];
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			audio_out <= '0;
		end else begin
			audio_out.l <= audio_pkg::vol_scale(pick.l, cfg.master_l);
			audio_out.r <= audio_pkg::vol_scale(pick.r, cfg.master_r);
		end
	end

endmodule

`default_nettype wire

// File: audio_path_top.sv
// Audio path top: input stabilizers, source mixer and master output stage
`timescale 1ns/100ps
`default_nettype none

module audio_path_top (
	input  logic                clk_sys,
	input  logic                reset,
	input  audio_pkg::stereo_t  sb_in,
	input  audio_pkg::stereo_t  opl_in,
	input  audio_pkg::stereo_t  midi_in,
	input  audio_pkg::stereo_t  cdda_in,
	input  logic                speaker,
	input  audio_pkg::mix_cfg_t cfg,
	output audio_pkg::stereo_t  audio_out
);

	audio_pkg::stereo_t  sb_stable;
	audio_pkg::mix_cfg_t cfg_stable;
	audio_pkg::stereo_t  mix;

	// Sound card samples come from a foreign domain
	sample_stabilizer #(.payload_t(audio_pkg::stereo_t)) sb_sync (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (sb_in),
		.dout    (sb_stable)
	);

	sample_stabilizer #(.payload_t(audio_pkg::mix_cfg_t)) cfg_sync (
		.clk_sys (clk_sys),
		.reset   (reset),
		.din     (cfg),
		.dout    (cfg_stable)
	);

	source_mixer mixer (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sb      (sb_stable),
		.opl     (opl_in),
		.midi    (midi_in),
		.cdda    (cdda_in),
		.speaker (speaker),
		.cfg     (cfg_stable),
		.mix_out (mix)
	);

	master_output master (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.mix_in    (mix),
		.cfg       (cfg_stable),
		.audio_out (audio_out)
	);

endmodule

`default_nettype wire

// File: audio_sva.sv
// Bound assertions on audio_out: cleared by reset and never unknown afterwards
`timescale 1ns/100ps
`default_nettype none

module audio_sva (
	input logic               clk_sys,
	input logic               reset,
	input audio_pkg::stereo_t audio_out
);

	// Output register clears on every reset cycle
	reset_clears_output: assert property (
		@(posedge clk_sys) reset |=> audio_out == '0
	) else $error("audio_out not zero in the cycle after reset");

	no_unknown_output: assert property (
		@(posedge clk_sys) disable iff (reset) !$isunknown(audio_out)
	) else $error("audio_out has unknown bits outside reset");

endmodule

bind audio_path_top audio_sva sva_check (
	.clk_sys   (clk_sys),
	.reset     (reset),
	.audio_out (audio_out)
);

`default_nettype wire

// File: audio_tb.sv
// Audio path testbench: clock, reset, stimulus, reference model, compare tasks and timeout
`timescale 1ns/100ps
`default_nettype none
`include "audio_consts.svh"

module audio_tb;

	localparam int AW = `AUDIO_W;
	localparam int SW = `SUM_W;
	localparam int HOLD = 24;
	localparam int RESET_CYCLES = 3;
	localparam int NUM_VECTORS = 77;
	localparam int CYCLE_LIMIT = (RESET_CYCLES + 1 + NUM_VECTORS * (HOLD + 1)) * 3 / 2;

	logic                clk_sys;
	logic                reset;
	audio_pkg::stereo_t  sb_in;
	audio_pkg::stereo_t  opl_in;
	audio_pkg::stereo_t  midi_in;
	audio_pkg::stereo_t  cdda_in;
	logic                speaker;
	audio_pkg::mix_cfg_t cfg;
	audio_pkg::stereo_t  audio_out;

	audio_pkg::stereo_t  exp_out;
	string               test_name;
	event                check_ev;
	integer              seed;
	int                  cycles;

	// Knee edges, both signs and the most negative sample
	logic signed [AW-1:0] knee_vals [10] = '{16'sd100, -16'sd100, 16'sd7398, 16'sd7399,
		-16'sd7399, 16'sd14042, 16'sd14043, -16'sd14043, 16'sd30000, 16'h8000};

	audio_path_top uut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.sb_in     (sb_in),
		.opl_in    (opl_in),
		.midi_in   (midi_in),
		.cdda_in   (cdda_in),
		.speaker   (speaker),
		.cfg       (cfg),
		.audio_out (audio_out)
	);

	always #5 clk_sys = ~clk_sys;

	//////////////////////////////
	// Reference model
	//////////////////////////////

	// Zero code mutes, upper four bits of the code set the shift
	function automatic logic signed [AW-1:0] scale_ref(input int s, input int code);
		if (code == 0) begin
			return '0;
		end
		return AW'(s >>> (15 - code / 2));
	endfunction

	function automatic logic signed [AW-1:0] clamp_ref(input logic signed [SW-1:0] s);
		int hi;
		int lo;
		hi = (2 ** (AW - 1)) - 1;
		lo = -(2 ** (AW - 1));
		if (int'(s) > hi) begin
			return AW'(hi);
		end
		if (int'(s) < lo) begin
			return AW'(lo);
		end
		return AW'(s);
	endfunction

	// Gain below the knee, divided slope plus offset above it
	function automatic logic signed [AW-1:0] comp_ref(input logic signed [AW-1:0] s,
			input logic steep);
		int mag;
		int x;
		int a;
		int f;
		int b;
		int y;
		mag = (s < 0) ? -int'(s) : int'(s);
		x = steep ? `COMP_X2 : `COMP_X1;
		a = steep ? `COMP_A2 : `COMP_A1;
		f = steep ? `COMP_F2 : `COMP_F1;
		b = steep ? `COMP_B2 : `COMP_B1;
		y = (mag < x) ? mag * a : (mag - x) / f + b;
		y = y % (2 ** AW);
		return AW'((s < 0) ? -y : y);
	endfunction

	function automatic audio_pkg::stereo_t expected_out(
		input audio_pkg::stereo_t  sb,
		input audio_pkg::stereo_t  opl,
		input audio_pkg::stereo_t  midi,
		input audio_pkg::stereo_t  cdda,
		input logic                spk,
		input audio_pkg::mix_cfg_t c
	);
		audio_pkg::mix_sum_t sum;
		audio_pkg::stereo_t  mixed;
		audio_pkg::stereo_t  res;
		int                  ml;
		int                  mr;
		int                  spk_lvl;
		int                  cd_l;
		int                  cd_r;
		ml = c.midi_src_line ? (c.line_en ? int'(c.vol_line_l) : 0) : int'(c.vol_midi_l);
		mr = c.midi_src_line ? (c.line_en ? int'(c.vol_line_r) : 0) : int'(c.vol_midi_r);
		spk_lvl = spk ? (1 << (`SPK_BASE_SHIFT + c.spk_boost)) >> (3 - c.spk_vol) : 0;
		cd_l = c.cd_en ? int'(cdda.l) : 0;
		cd_r = c.cd_en ? int'(cdda.r) : 0;
		sum.l = SW'(int'(sb.l) + int'(opl.l) + int'(scale_ref(midi.l, ml)) + spk_lvl + cd_l);
		sum.r = SW'(int'(sb.r) + int'(opl.r) + int'(scale_ref(midi.r, mr)) + spk_lvl + cd_r);
		mixed.l = clamp_ref(sum.l);
		mixed.r = clamp_ref(sum.r);
		if (c.boost != 2'd0) begin
			mixed.l = comp_ref(mixed.l, c.boost[1]);
			mixed.r = comp_ref(mixed.r, c.boost[1]);
		end
		res.l = scale_ref(mixed.l, int'(c.master_l));
		res.r = scale_ref(mixed.r, int'(c.master_r));
		return res;
	endfunction

	//////////////////////////////
	// Checks and timeout
	//////////////////////////////

	task automatic check_sample(input logic signed [AW-1:0] got,
			input logic signed [AW-1:0] exp, input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t ns: %s, got %0d, expected %0d", $time, what, got, exp);
			$display("Simulation failed");
			$fatal(1, "output value check");
		end
	endtask

	task automatic check_stereo(input audio_pkg::stereo_t got, input audio_pkg::stereo_t exp,
			input string what);
		check_sample(got.l, exp.l, {what, " left"});
		check_sample(got.r, exp.r, {what, " right"});
	endtask

	always @(check_ev) begin
		check_stereo(audio_out, exp_out, test_name);
	end

	always @(posedge clk_sys) begin
		cycles = cycles + 1;
		if (cycles >= CYCLE_LIMIT) begin
			$display("Timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("Simulation failed");
			$fatal(1, "timeout");
		end
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	function automatic audio_pkg::stereo_t stereo_of(input int l, input int r);
		audio_pkg::stereo_t s;
		s.l = AW'(l);
		s.r = AW'(r);
		return s;
	endfunction

	function automatic audio_pkg::stereo_t random_stereo();
		audio_pkg::stereo_t s;
		s.l = AW'($random(seed));
		s.r = AW'($random(seed));
		return s;
	endfunction

	// Full volumes, line enabled, CD on, no boost
	function automatic audio_pkg::mix_cfg_t unity_cfg();
		audio_pkg::mix_cfg_t c;
		c = '0;
		c.vol_midi_l = 5'd31;
		c.vol_midi_r = 5'd31;
		c.vol_line_l = 5'd31;
		c.vol_line_r = 5'd31;
		c.master_l = 5'd31;
		c.master_r = 5'd31;
		c.line_en = 1'b1;
		c.cd_en = 1'b1;
		return c;
	endfunction

	// Drive on the falling edge, hold, then hand over to the checker
	task automatic apply(input audio_pkg::stereo_t sb, opl, midi, cdda, input logic spk,
			input audio_pkg::mix_cfg_t c, input string name);
		@(negedge clk_sys);
		sb_in = sb;
		opl_in = opl;
		midi_in = midi;
		cdda_in = cdda;
		speaker = spk;
		cfg = c;
		exp_out = expected_out(sb, opl, midi, cdda, spk, c);
		test_name = name;
		repeat (HOLD) @(negedge clk_sys);
		-> check_ev;
	endtask

	initial begin
		audio_pkg::stereo_t  zero;
		audio_pkg::mix_cfg_t c;
		logic signed [AW-1:0] v;
		seed = 78679;
		cycles = 0;
		clk_sys = 1'b0;
		reset = 1'b1;
		sb_in = '0;
		opl_in = '0;
		midi_in = '0;
		cdda_in = '0;
		speaker = 1'b0;
		cfg = '0;
		exp_out = '0;
		zero = '0;
		test_name = "after reset";
		repeat (RESET_CYCLES) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		-> check_ev;

		// Sums, clamping at both limits, CD gating
		c = unity_cfg();
		apply(stereo_of(1000, -2000), stereo_of(300, 400), zero, stereo_of(-50, 70), 1'b0, c,
			"plain sum");
		apply(stereo_of(30000, 20000), stereo_of(5000, 20000), zero, stereo_of(1, 0), 1'b0, c,
			"clamp high");
		apply(stereo_of(-30000, -20000), stereo_of(-5000, -20000), zero, stereo_of(-1, 0), 1'b0,
			c, "clamp low");
		c.cd_en = 1'b0;
		apply(stereo_of(100, 200), stereo_of(300, 400), zero, stereo_of(9999, -9999), 1'b0, c,
			"cdda dropped");
		c.cd_en = 1'b1;
		for (int i = 0; i < 8; i++) begin
			apply(random_stereo(), random_stereo(), zero, random_stereo(), 1'b0, c, "random sum");
		end

		// MIDI through its own volume and through line-in
		for (int i = 0; i < 4; i++) begin
			c = unity_cfg();
			c.vol_midi_l = 5'(31 - 7 * i);
			c.vol_midi_r = 5'(7 * i);
			apply(zero, zero, random_stereo(), zero, 1'b0, c, "midi volume");
			c.midi_src_line = 1'b1;
			c.vol_line_l = 5'(3 + 9 * i);
			c.vol_line_r = 5'(28 - 9 * i);
			apply(zero, zero, random_stereo(), zero, 1'b0, c, "line volume");
		end
		c.line_en = 1'b0;
		apply(zero, zero, random_stereo(), zero, 1'b0, c, "line disabled");

		c = unity_cfg();
		for (int i = 0; i < 16; i++) begin
			c.spk_vol = 2'(i);
			c.spk_boost = 2'(i >> 2);
			apply(zero, zero, zero, zero, 1'b1, c, "speaker level");
		end

		// Both compressor curves
		for (int b = 1; b <= 2; b++) begin
			c = unity_cfg();
			c.boost = 2'(b);
			foreach (knee_vals[i]) begin
				v = knee_vals[i];
				apply(zero, stereo_of(v, -v), zero, zero, 1'b0, c, "boost knee");
			end
			for (int i = 0; i < 6; i++) begin
				apply(random_stereo(), random_stereo(), zero, zero, 1'b0, c, "boost random");
			end
		end

		// Master volume
		c = unity_cfg();
		c.master_l = 5'd0;
		apply(zero, random_stereo(), zero, zero, 1'b0, c, "left mute");
		c.master_l = 5'd31;
		c.master_r = 5'd0;
		apply(zero, random_stereo(), zero, zero, 1'b0, c, "right mute");
		for (int i = 0; i < 4; i++) begin
			c.master_l = 5'(6 + 7 * i);
			c.master_r = 5'(27 - 6 * i);
			apply(zero, random_stereo(), zero, zero, 1'b0, c, "master volume");
		end

		// A sound card sample that never settles must not pass
		c = unity_cfg();
		apply(stereo_of(1234, -4321), stereo_of(10, 20), zero, zero, 1'b0, c, "steady sb");
		test_name = "toggling sb";
		for (int k = 0; k < HOLD; k++) begin
			@(negedge clk_sys);
			sb_in = stereo_of(k * 1237 + 5, -k * 911 - 3);
		end
		@(negedge clk_sys);
		-> check_ev;
		@(negedge clk_sys);
		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

// File: sim.f
+incdir+.
audio_pkg.sv
sample_stabilizer.sv
source_mixer.sv
dynamics_compressor.sv
master_output.sv
audio_path_top.sv
audio_sva.sv
audio_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the simulation log
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module audio_tb -f sim.f -o audio_sim \
	&& ./obj_dir/audio_sim > sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
